// ==== common/regex_pkg.sv ====
// character, memory word and pointer widths, their vector types and the fetch state encoding
package regex_pkg;

    // bits per character
    localparam int CHAR_WIDTH = 8;

    // bits per memory word
    localparam int MEM_WIDTH = 16;

    // word address bits on the memory port
    localparam int MEM_ADDR_WIDTH = 11;

    // character pointer bits, as seen on the start handshake
    localparam int PTR_WIDTH = 32;

    // low pointer bits that pick a character inside a window
    // a run must start with these all zero
    localparam int CC_ID_BITS = 1;

    // characters packed into one memory word
    localparam int CHARS_PER_WORD = MEM_WIDTH / CHAR_WIDTH;

    typedef logic [CHAR_WIDTH-1:0]     char_t;
    typedef logic [MEM_WIDTH-1:0]      mem_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // character pointer, upper bits hold the word address
    typedef logic [PTR_WIDTH-1:0]      cc_ptr_t;

    // fetch FSM states
    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_DATA,
        FETCH_PUSH,
        FETCH_ERROR
    } fetch_state_t;

endpackage

// ==== fetch/cc_fetch.sv ====
// character fetch FSM with start handshake, word reads, character unpacking and end-of-string tagging
`timescale 1ns/100ps

module cc_fetch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    output logic                 ready,
    input  regex_pkg::cc_ptr_t   start_cc_pointer,
    input  regex_pkg::cc_ptr_t   end_cc_pointer,
    output logic                 memory_valid,
    output regex_pkg::mem_addr_t memory_addr,
    input  logic                 memory_ready,
    input  regex_pkg::mem_word_t memory_data,
    output logic                 push,
    output regex_pkg::char_t     push_char,
    output logic                 push_eos,
    input  logic                 full,
    input  logic                 run_done,
    input  logic                 busy,
    output logic                 error
);
    import regex_pkg::*;

    // pointer bits that select a character inside a memory word
    localparam int WORD_OFFSET_BITS = $clog2(CHARS_PER_WORD);

    fetch_state_t                state;
    fetch_state_t                next_state;

    // current character pointer and the word it lives in
    cc_ptr_t                     cur_ptr;
    mem_word_t                   word_q;

    // end-of-string already handed to the FIFO
    logic                        eos_sent_q;
    // run finished while a read was still waiting for acceptance
    logic                        stop_q;

    logic [WORD_OFFSET_BITS-1:0] char_idx;
    logic                        start;
    logic                        aligned;
    logic                        last_in_word;

    assign char_idx     = cur_ptr[WORD_OFFSET_BITS-1:0];
    assign start        = valid && ready;
    assign aligned      = (start_cc_pointer[CC_ID_BITS-1:0] == '0);
    // chars per word is a power of two, so all ones marks the top char
    assign last_in_word = &char_idx;

    // new run only once the matcher has drained the previous one
    assign ready        = (state == FETCH_IDLE) && !busy;
    assign error        = (state == FETCH_ERROR);

    // address held stable by cur_ptr while the request waits
    assign memory_valid = (state == FETCH_REQ);
    assign memory_addr  = cur_ptr[WORD_OFFSET_BITS +: MEM_ADDR_WIDTH];

    // low char of the word sits at the lowest pointer
    assign push_char    = word_q[char_idx*CHAR_WIDTH +: CHAR_WIDTH];
    assign push_eos     = (cur_ptr == end_cc_pointer);
    // nothing more goes out after the end-of-string char
    assign push         = (state == FETCH_PUSH) && !eos_sent_q && !full;

    always_comb
    begin
        next_state = state;
        case (state)
            FETCH_IDLE:
            begin
                // misaligned start is fatal until reset
                if (start && aligned)
                begin
                    next_state = FETCH_REQ;
                end
                else if (start)
                begin
                    next_state = FETCH_ERROR;
                end
            end
            FETCH_REQ:
            begin
                // request cannot be withdrawn, wait for acceptance first
                if (memory_ready && (stop_q || run_done))
                begin
                    next_state = FETCH_IDLE;
                end
                else if (memory_ready)
                begin
                    next_state = FETCH_DATA;
                end
            end
            FETCH_DATA:
            begin
                if (run_done)
                begin
                    next_state = FETCH_IDLE;
                end
                else
                begin
                    next_state = FETCH_PUSH;
                end
            end
            FETCH_PUSH:
            begin
                // stays here after end-of-string until the matcher reports
                if (run_done)
                begin
                    next_state = FETCH_IDLE;
                end
                else if (push && !push_eos && last_in_word)
                begin
                    next_state = FETCH_REQ;
                end
            end
            FETCH_ERROR:
            begin
                next_state = FETCH_ERROR;
            end
            default:
            begin
                next_state = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= FETCH_IDLE;
            eos_sent_q <= 1'b0;
            stop_q     <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == FETCH_IDLE)
            begin
                eos_sent_q <= 1'b0;
                stop_q     <= 1'b0;
            end
            else
            begin
                if (push && push_eos)
                begin
                    eos_sent_q <= 1'b1;
                end
                if ((state == FETCH_REQ) && run_done)
                begin
                    stop_q <= 1'b1;
                end
            end
        end
    end

    // pointer walks one char per accepted push
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            cur_ptr <= start_cc_pointer;
        end
        else if (push)
        begin
            cur_ptr <= cur_ptr + cc_ptr_t'(1);
        end
        // memory data is valid the cycle after acceptance
        if (state == FETCH_DATA)
        begin
            word_q <= memory_data;
        end
    end

endmodule

// ==== rtl/cc_fifo.sv ====
// synchronous circular FIFO of characters with end-of-string tags and a flush input
`timescale 1ns/100ps

module cc_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             push,
    input  regex_pkg::char_t push_char,
    input  logic             push_eos,
    output logic             full,
    input  logic             pop,
    output regex_pkg::char_t pop_char,
    output logic             pop_eos,
    output logic             empty
);
    import regex_pkg::*;

    localparam int ADDR_BITS  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

    // char and its tag stored side by side
    char_t                 char_mem [FIFO_DEPTH];
    logic                  eos_mem  [FIFO_DEPTH];

    logic [ADDR_BITS-1:0]  wr_ptr;
    logic [ADDR_BITS-1:0]  rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  push_ok;
    logic                  pop_ok;

    // wrap explicitly, depth need not be a power of two
    function automatic logic [ADDR_BITS-1:0] next_ptr(input logic [ADDR_BITS-1:0] ptr);
        if (ptr == ADDR_BITS'(FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == COUNT_BITS'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign push_ok  = push && !full;
    assign pop_ok   = pop && !empty;

    // head of queue shown without a read latency
    assign pop_char = char_mem[rd_ptr];
    assign pop_eos  = eos_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push_ok)
        begin
            char_mem[wr_ptr] <= push_char;
            eos_mem[wr_ptr]  <= push_eos;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            // flush wins over a same-cycle push or pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push_ok && !pop_ok)
            begin
                count <= count + 1'b1;
            end
            else if (pop_ok && !push_ok)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/literal_matcher.sv ====
// literal substring matcher over the popped character stream with done and accept reporting
`timescale 1ns/100ps

module literal_matcher #(
    parameter int PATTERN_CHARS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  regex_pkg::char_t [PATTERN_CHARS-1:0] pattern,
    input  logic [$clog2(PATTERN_CHARS+1)-1:0]   pattern_len,
    input  logic                                 empty,
    output logic                                 pop,
    input  regex_pkg::char_t                     pop_char,
    input  logic                                 pop_eos,
    output logic                                 busy,
    output logic                                 done,
    output logic                                 accept
);
    import regex_pkg::*;

    localparam int LEN_BITS = $clog2(PATTERN_CHARS + 1);

    // history of popped chars, index 0 is the newest
    char_t [PATTERN_CHARS-1:0] hist_q;
    char_t [PATTERN_CHARS-1:0] next_hist;

    // chars seen this run, saturates at the pattern size
    logic [LEN_BITS-1:0]       seen_q;
    logic [LEN_BITS-1:0]       next_seen;

    logic                      busy_q;
    logic                      done_q;
    logic                      accept_q;
    logic                      match;

    // one char per cycle, stop once the result is out
    assign pop    = !empty && !done_q;
    assign busy   = busy_q;
    assign done   = done_q;
    assign accept = accept_q;

    // history as it would look with the current char shifted in
    always_comb
    begin
        next_hist[0] = pop_char;
        for (int i = 1; i < PATTERN_CHARS; i++)
        begin
            next_hist[i] = hist_q[i-1];
        end
    end

    assign next_seen = (seen_q == LEN_BITS'(PATTERN_CHARS)) ? seen_q : seen_q + 1'b1;

    // newest char lines up with the last pattern char,
    // pattern char 0 with the oldest one in the window
    always_comb
    begin
        int pidx;
        match = (next_seen >= pattern_len);
        for (int i = 0; i < PATTERN_CHARS; i++)
        begin
            pidx = int'(pattern_len) - 1 - i;
            if ((pidx >= 0) && (next_hist[i] != pattern[pidx]))
            begin
                match = 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            accept_q <= 1'b0;
            seen_q   <= '0;
        end
        else if (done_q)
        begin
            // single-cycle result, then ready for the next run
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            accept_q <= 1'b0;
            seen_q   <= '0;
        end
        else if (pop)
        begin
            busy_q <= 1'b1;
            seen_q <= next_seen;
            if (match)
            begin
                done_q   <= 1'b1;
                accept_q <= 1'b1;
            end
            else if (pop_eos)
            begin
                // end of string reached without a hit
                done_q <= 1'b1;
            end
        end
    end

    // stale history is masked by seen_q
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            hist_q <= next_hist;
        end
    end

endmodule

// ==== rtl/coprocessor_top.sv ====
// coprocessor top level joining character fetch, character FIFO and literal matcher
`timescale 1ns/100ps

module coprocessor_top #(
    parameter int FIFO_DEPTH    = 4,
    parameter int PATTERN_CHARS = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   valid,
    output logic                                   ready,
    input  regex_pkg::cc_ptr_t                     start_cc_pointer,
    input  regex_pkg::cc_ptr_t                     end_cc_pointer,
    output logic                                   memory_valid,
    output regex_pkg::mem_addr_t                   memory_addr,
    input  logic                                   memory_ready,
    input  regex_pkg::mem_word_t                   memory_data,
    input  regex_pkg::char_t [PATTERN_CHARS-1:0]   pattern,
    input  logic [$clog2(PATTERN_CHARS+1)-1:0]     pattern_len,
    output logic                                   done,
    output logic                                   accept,
    output logic                                   error
);
    import regex_pkg::*;

    // push side, fetch into FIFO
    logic  push;
    char_t push_char;
    logic  push_eos;
    logic  full;

    // pop side, FIFO into matcher
    logic  pop;
    char_t pop_char;
    logic  pop_eos;
    logic  empty;

    // matcher holds off new starts while draining
    logic  busy;

    cc_fetch u_cc_fetch (
        .clk              (clk),
        .rst              (rst),
        .valid            (valid),
        .ready            (ready),
        .start_cc_pointer (start_cc_pointer),
        .end_cc_pointer   (end_cc_pointer),
        .memory_valid     (memory_valid),
        .memory_addr      (memory_addr),
        .memory_ready     (memory_ready),
        .memory_data      (memory_data),
        .push             (push),
        .push_char        (push_char),
        .push_eos         (push_eos),
        .full             (full),
        .run_done         (done),
        .busy             (busy),
        .error            (error)
    );

    // done also flushes whatever the run left behind
    cc_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cc_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (done),
        .push      (push),
        .push_char (push_char),
        .push_eos  (push_eos),
        .full      (full),
        .pop       (pop),
        .pop_char  (pop_char),
        .pop_eos   (pop_eos),
        .empty     (empty)
    );

    literal_matcher #(
        .PATTERN_CHARS (PATTERN_CHARS)
    ) u_literal_matcher (
        .clk         (clk),
        .rst         (rst),
        .pattern     (pattern),
        .pattern_len (pattern_len),
        .empty       (empty),
        .pop         (pop),
        .pop_char    (pop_char),
        .pop_eos     (pop_eos),
        .busy        (busy),
        .done        (done),
        .accept      (accept)
    );

endmodule

// ==== dv/coprocessor_assert.sv ====
// bound protocol, pulse, error and reset assertions on the coprocessor top-level ports
`timescale 1ns/100ps

module coprocessor_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 valid,
    input logic                 ready,
    input regex_pkg::cc_ptr_t   start_cc_pointer,
    input logic                 memory_valid,
    input regex_pkg::mem_addr_t memory_addr,
    input logic                 memory_ready,
    input logic                 done,
    input logic                 accept,
    input logic                 error
);
    import regex_pkg::*;

    // failed assertions so far, read by the testbench
    int   fail_count = 0;

    logic start_seen;
    logic aligned_start;
    logic run_active;

    assign start_seen    = valid && ready;
    assign aligned_start = start_seen && (start_cc_pointer[CC_ID_BITS-1:0] == '0);

    // high from an aligned start until its done pulse
    always_ff @(posedge clk)
    begin
        if (rst || done)
        begin
            run_active <= 1'b0;
        end
        else if (aligned_start)
        begin
            run_active <= 1'b1;
        end
    end

    // outputs one cycle into reset
    reset_values: assert property (@(posedge clk)
        rst |=> (ready && !done && !accept && !error && !memory_valid))
        else begin fail_count++; $error("outputs not at reset values"); end

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin fail_count++; $error("done longer than one cycle"); end

    accept_with_done: assert property (@(posedge clk) disable iff (rst) accept |-> done)
        else begin fail_count++; $error("accept without done"); end

    busy_not_ready: assert property (@(posedge clk) disable iff (rst) run_active |-> !ready)
        else begin fail_count++; $error("ready high during a run"); end

    first_request: assert property (@(posedge clk) disable iff (rst)
        aligned_start |=> memory_valid)
        else begin fail_count++; $error("no memory request after start"); end

    request_held: assert property (@(posedge clk) disable iff (rst)
        (memory_valid && !memory_ready) |=> (memory_valid && $stable(memory_addr)))
        else begin fail_count++; $error("memory request dropped or moved"); end

    misaligned_error: assert property (@(posedge clk) disable iff (rst)
        (start_seen && !aligned_start) |=> error)
        else begin fail_count++; $error("misaligned start without error"); end

    error_sticky: assert property (@(posedge clk) disable iff (rst) error |=> error)
        else begin fail_count++; $error("error cleared without reset"); end

    error_quiet: assert property (@(posedge clk) disable iff (rst)
        error |-> (!ready && !memory_valid))
        else begin fail_count++; $error("activity while in error"); end

endmodule

bind coprocessor_top coprocessor_assert u_coprocessor_assert (.*);

// ==== dv/coprocessor_tb.sv ====
// testbench for coprocessor_top with clock, reset, memory model, match model, tests and timeout
`timescale 1ns/100ps

module coprocessor_tb;
    import regex_pkg::*;

    localparam int FIFO_DEPTH    = 4;
    localparam int PATTERN_CHARS = 4;
    localparam int LEN_BITS      = $clog2(PATTERN_CHARS + 1);
    localparam int TEXT_CHARS    = 128;
    // string lengths of all tests in run order
    localparam int TOTAL_CHARS    = 10 + 9 + 10 + 8 + 8 + 10 + 10 + 5 + 10;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_CHARS;

    typedef char_t [PATTERN_CHARS-1:0] pattern_t;

    logic                clk;
    logic                rst;
    logic                valid;
    logic                ready;
    cc_ptr_t             start_cc_pointer;
    cc_ptr_t             end_cc_pointer;
    logic                memory_valid;
    mem_addr_t           memory_addr;
    logic                memory_ready;
    mem_word_t           memory_data;
    pattern_t            pattern;
    logic [LEN_BITS-1:0] pattern_len;
    logic                done;
    logic                accept;
    logic                error;

    // character image behind the memory port
    // the low char of each word sits at the even pointer
    char_t  text [TEXT_CHARS];
    integer seed = 32'h9527;
    int     check_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycle_count = 0;
    // memory model controls set at the start of each run
    bit     long_stall = 1'b0;
    int     words_accepted = 0;
    int     gap_cycles = 0;

    coprocessor_top #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .PATTERN_CHARS (PATTERN_CHARS)
    ) u_coprocessor_top (
        .clk              (clk),
        .rst              (rst),
        .valid            (valid),
        .ready            (ready),
        .start_cc_pointer (start_cc_pointer),
        .end_cc_pointer   (end_cc_pointer),
        .memory_valid     (memory_valid),
        .memory_addr      (memory_addr),
        .memory_ready     (memory_ready),
        .memory_data      (memory_data),
        .pattern          (pattern),
        .pattern_len      (pattern_len),
        .done             (done),
        .accept           (accept),
        .error            (error)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // runaway guard over the whole run
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: no result after %0d cycles, the run is stuck", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // word beyond the image gets a filler built from the full address
    function automatic mem_word_t word_at(input mem_addr_t addr);
        mem_word_t word;
        int        idx;
        word = mem_word_t'(addr) ^ 16'ha5a5;
        for (int j = 0; j < CHARS_PER_WORD; j++)
        begin
            idx = int'(addr) * CHARS_PER_WORD + j;
            if (idx < TEXT_CHARS)
            begin
                word[j*CHAR_WIDTH +: CHAR_WIDTH] = text[idx];
            end
        end
        return word;
    endfunction

    // memory model samples requests at the negedge
    // data follows in the cycle after acceptance
    initial
    begin
        bit        taken;
        mem_addr_t addr;
        memory_ready = 1'b0;
        memory_data  = '0;
        forever
        begin
            @(negedge clk);
            taken = memory_valid && memory_ready;
            addr  = memory_addr;
            @(posedge clk);
            #10;
            if (taken)
            begin
                memory_data = word_at(addr);
                words_accepted++;
                // long gap after the first word lets the FIFO run dry
                if (long_stall && (words_accepted == 1))
                begin
                    gap_cycles = 24;
                end
            end
            if (gap_cycles > 0)
            begin
                memory_ready = 1'b0;
                gap_cycles--;
            end
            else
            begin
                memory_ready = (($random(seed) & 3) != 0);
            end
        end
    end

    task automatic place(input int base, input string s);
        for (int i = 0; i < s.len(); i++)
        begin
            text[base+i] = s[i];
        end
    endtask

    function automatic pattern_t to_pattern(input string pat);
        pattern_t p;
        // unused slots hold a char that never occurs in the image
        for (int k = 0; k < PATTERN_CHARS; k++)
        begin
            p[k] = (k < pat.len()) ? pat[k] : 8'h3f;
        end
        return p;
    endfunction

    // accept when any window inside start..end equals the pattern
    function automatic bit expected_accept(input int start_ptr, input int end_ptr,
                                           input string pat);
        int len;
        bit hit;
        bit same;
        len = pat.len();
        hit = 1'b0;
        for (int e = start_ptr + len - 1; e <= end_ptr; e++)
        begin
            same = 1'b1;
            for (int k = 0; k < len; k++)
            begin
                if (text[e-len+1+k] != pat[k])
                begin
                    same = 1'b0;
                end
            end
            hit |= same;
        end
        return hit;
    endfunction

    function automatic int failure_total();
        return check_errors + u_coprocessor_top.u_coprocessor_assert.fail_count;
    endfunction

    task automatic check_bit(input string name, input string what, input bit expected,
                             input bit actual);
        assert (actual == expected)
        else
        begin
            $display("[ERROR] %s %s expected %0b actual %0b", name, what, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int expected,
                               input int actual);
        assert (actual == expected)
        else
        begin
            $display("[ERROR] %s %s expected %0d actual %0d", name, what, expected, actual);
            check_errors++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        tests_run++;
        if (failure_total() > fails_before)
        begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
        else
        begin
            $display("test %s: pass", name);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #10 rst = 1'b1;
        repeat (3) @(posedge clk);
        #10 rst = 1'b0;
    endtask

    // drive a start request and hold it until the handshake edge
    task automatic start_run(input int start_ptr, input int end_ptr, input string pat);
        @(posedge clk);
        #10;
        start_cc_pointer = cc_ptr_t'(start_ptr);
        end_cc_pointer   = cc_ptr_t'(end_ptr);
        pattern          = to_pattern(pat);
        pattern_len      = LEN_BITS'(pat.len());
        valid            = 1'b1;
        @(negedge clk);
        while (!ready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #10 valid = 1'b0;
    endtask

    task automatic run_test(input string name, input int start_ptr, input int end_ptr,
                            input string pat, input bit stall);
        bit exp;
        int fails_before;
        int words_expected;
        fails_before   = failure_total();
        exp            = expected_accept(start_ptr, end_ptr, pat);
        words_expected = end_ptr / CHARS_PER_WORD - start_ptr / CHARS_PER_WORD + 1;
        start_run(start_ptr, end_ptr, pat);
        // no request is out on the handshake edge, so counting starts clean here
        long_stall     = stall;
        words_accepted = 0;
        // pointers stay driven until done
        @(negedge clk);
        while (!done)
        begin
            @(negedge clk);
        end
        check_bit(name, "accept", exp, accept);
        if (!exp)
        begin
            // without a hit every word up to the end pointer is read and none beyond
            check_count(name, "words read", words_expected, words_accepted);
        end
        report_test(name, fails_before);
    endtask

    task automatic run_misaligned(input string name, input int start_ptr, input int end_ptr);
        int fails_before;
        fails_before = failure_total();
        long_stall   = 1'b0;
        start_run(start_ptr, end_ptr, "abcd");
        // error must hold with no memory traffic
        repeat (6)
        begin
            @(negedge clk);
            check_bit(name, "error", 1'b1, error);
            check_bit(name, "ready", 1'b0, ready);
            check_bit(name, "memory_valid", 1'b0, memory_valid);
        end
        apply_reset();
        @(negedge clk);
        check_bit(name, "error after reset", 1'b0, error);
        check_bit(name, "ready after reset", 1'b1, ready);
        report_test(name, fails_before);
    endtask

    initial
    begin
        rst              = 1'b1;
        valid            = 1'b0;
        start_cc_pointer = '0;
        end_cc_pointer   = '0;
        pattern          = '0;
        pattern_len      = '0;
        for (int i = 0; i < TEXT_CHARS; i++)
        begin
            text[i] = char_t'(8'h80 | i);
        end
        place(0, "zzabcdzzzz");
        // pattern completes only past the end pointer in the next two
        place(16, "abcxabdabcd");
        place(32, "aabbccddabcd");
        place(48, "xyzqrsxy");
        place(56, "mnopabcd");
        apply_reset();

        run_test("match_mid", 0, 9, "abcd", 1'b0);
        run_test("no_match_word_mid", 16, 24, "abcd", 1'b0);
        run_test("no_match_word_end", 32, 41, "abcd", 1'b0);
        run_test("match_len2", 48, 55, "zq", 1'b0);
        run_test("match_at_end", 56, 63, "abcd", 1'b0);
        run_test("stall_match", 0, 9, "abcd", 1'b1);
        run_test("stall_no_match", 32, 41, "abcd", 1'b1);
        run_misaligned("misaligned_start", 5, 9);
        run_test("match_after_reset", 0, 9, "abcd", 1'b0);

        $display("tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, check_errors,
                 u_coprocessor_top.u_coprocessor_assert.fail_count);
        if (failure_total() == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== regex_coprocessor.f ====
common/regex_pkg.sv
fetch/cc_fetch.sv
rtl/cc_fifo.sv
rtl/literal_matcher.sv
rtl/coprocessor_top.sv
dv/coprocessor_assert.sv
dv/coprocessor_tb.sv

// ==== Bender.yml ====
package:
  name: regex_coprocessor

sources:
  # design
  - files:
      - common/regex_pkg.sv
      - fetch/cc_fetch.sv
      - rtl/cc_fifo.sv
      - rtl/literal_matcher.sv
      - rtl/coprocessor_top.sv
  # testbench
  - target: test
    files:
      - dv/coprocessor_assert.sv
      - dv/coprocessor_tb.sv
